// ==== crc_pkg.sv ====
package crc_pkg;

	//////////////////////////////////////////////////
	// Register map, word offsets from HADDR[4:2]
	//////////////////////////////////////////////////
	localparam logic [2:0] CRC_DR   = 3'd0;
	localparam logic [2:0] CRC_IDR  = 3'd1;
	localparam logic [2:0] CRC_CR   = 3'd2;
	localparam logic [2:0] CRC_INIT = 3'd4;
	localparam logic [2:0] CRC_POL  = 3'd5;

	// Control bits held in the register: rev_out, rev_in, poly_size
	localparam logic [4:0] CRC_CR_RESET = 5'h00;

	//////////////////////////////////////////////////
	// Field encodings
	//////////////////////////////////////////////////

	// Transfer size, low bits of HSIZE
	typedef enum logic [1:0] {
		SIZE_BYTE = 2'b00,
		SIZE_HALF = 2'b01,
		SIZE_WORD = 2'b10
	} crc_size_e;

	// CRC width, CR bits 4:3
	typedef enum logic [1:0] {
		POLY_32 = 2'b00,
		POLY_16 = 2'b01,
		POLY_8  = 2'b10,
		POLY_7  = 2'b11
	} crc_poly_size_e;

	// Input bit reversal, CR bits 6:5
	typedef enum logic [1:0] {
		REV_NONE = 2'b00,
		REV_BYTE = 2'b01,
		REV_HALF = 2'b10,
		REV_WORD = 2'b11
	} crc_rev_in_e;

	// One data word, seen whole, as halfwords or as byte lanes
	typedef union packed {
		logic [31:0]      word;
		logic [1:0][15:0] half;
		logic [3:0][7:0]  bytes;
	} crc_word_u;

endpackage

// ==== crc_if.sv ====
`timescale 1ns/100ps

// Configuration and register contents between bus slave and CRC core
interface crc_cfg_if import crc_pkg::*; ();
	logic [31:0]    bus_wr;
	logic           crc_init_en;
	logic           crc_idr_en;
	logic           crc_poly_en;
	crc_poly_size_e crc_poly_size;
	crc_rev_in_e    rev_in_type;
	logic           rev_out_type;
	logic [31:0]    crc_out;
	logic [31:0]    crc_init_out;
	logic [31:0]    crc_poly_out;
	logic [7:0]     crc_idr_out;

	modport host (
		output bus_wr, crc_init_en, crc_idr_en, crc_poly_en,
		output crc_poly_size, rev_in_type, rev_out_type,
		input  crc_out, crc_init_out, crc_poly_out, crc_idr_out
	);

	modport core (
		input  bus_wr, crc_init_en, crc_idr_en, crc_poly_en,
		input  crc_poly_size, rev_in_type, rev_out_type,
		output crc_out, crc_init_out, crc_poly_out, crc_idr_out
	);
endinterface

// Data word path from bus slave into the input FIFO
interface crc_buf_if import crc_pkg::*; ();
	logic        buffer_write_en;
	logic [31:0] bus_wr;
	crc_size_e   bus_size;
	logic        buffer_full;

	modport host (output buffer_write_en, bus_wr, bus_size, input buffer_full);
	modport buffer (input buffer_write_en, bus_wr, bus_size, output buffer_full);
endinterface

// ==== host_interface.sv ====
`timescale 1ns/100ps

module host_interface import crc_pkg::*; (
	input  logic        HCLK,
	input  logic        HRESETn,
	input  logic [31:0] HADDR,
	input  logic [31:0] HWDATA,
	input  logic [2:0]  HSIZE,
	input  logic [1:0]  HTRANS,
	input  logic        HWRITE,
	input  logic        HSElx,
	input  logic        HREADY,
	output logic [31:0] HRDATA,
	output logic        HREADYOUT,
	output logic        HRESP,
	crc_cfg_if.host     cfg,
	crc_buf_if.host     buf_wr,
	output logic        reset_chain,
	input  logic        read_wait,
	input  logic        reset_pending
);

	// HTRANS codes that matter here
	localparam logic [1:0] TRANS_IDLE    = 2'b00;
	localparam logic [1:0] TRANS_NONSEQ  = 2'b10;

	logic [2:0] haddr_pp;
	crc_size_e  hsize_pp;
	logic [1:0] htrans_pp;
	logic       hwrite_pp;
	logic       hselx_pp;
	logic [4:0] cr_q;
	logic       sample_bus;
	logic       write_en;
	logic       read_en;
	logic       dr_wr;
	logic       dr_rd;
	logic       init_wr;
	logic       cr_en;

	//////////////////////////////////////////////////
	// Address phase pipeline
	//////////////////////////////////////////////////

	// Bus is only taken when no slave holds the transfer
	assign sample_bus = HREADY && HREADYOUT;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			hselx_pp  <= 1'b0;
			htrans_pp <= TRANS_IDLE;
		end
		else if (sample_bus)
		begin
			hselx_pp  <= HSElx;
			htrans_pp <= HTRANS;
		end
	end

	// Payload of the address phase
	always_ff @(posedge HCLK)
	begin
		if (sample_bus)
		begin
			haddr_pp  <= HADDR[4:2];
			hsize_pp  <= crc_size_e'(HSIZE[1:0]);
			hwrite_pp <= HWRITE;
		end
	end

	//////////////////////////////////////////////////
	// Decode and strobes
	//////////////////////////////////////////////////

	// Only NONSEQ transfers act
	assign write_en = hselx_pp && (htrans_pp == TRANS_NONSEQ) && hwrite_pp;
	assign read_en  = hselx_pp && (htrans_pp == TRANS_NONSEQ) && !hwrite_pp;

	assign dr_wr   = write_en && (haddr_pp == CRC_DR);
	assign dr_rd   = read_en && (haddr_pp == CRC_DR);
	assign init_wr = write_en && (haddr_pp == CRC_INIT);
	assign cr_en   = write_en && (haddr_pp == CRC_CR);

	// Strobes fire only on the cycle the data phase completes
	assign buf_wr.buffer_write_en = dr_wr && !buf_wr.buffer_full;
	assign cfg.crc_init_en        = init_wr && !reset_pending;
	assign cfg.crc_idr_en         = write_en && (haddr_pp == CRC_IDR);
	assign cfg.crc_poly_en        = write_en && (haddr_pp == CRC_POL);

	// Write data goes straight through
	assign cfg.bus_wr      = HWDATA;
	assign buf_wr.bus_wr   = HWDATA;
	assign buf_wr.bus_size = hsize_pp;

	// Wait states on a full FIFO, a CRC not yet final or a pending reload
	assign HREADYOUT = !((dr_wr && buf_wr.buffer_full) ||
	                     (dr_rd && read_wait) ||
	                     (init_wr && reset_pending));

	// No error response in this slave
	assign HRESP = 1'b0;

	//////////////////////////////////////////////////
	// Control register
	//////////////////////////////////////////////////
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			cr_q <= CRC_CR_RESET;
		else if (cr_en)
			cr_q <= HWDATA[7:3];
	end

	// Bit 0 is a pulse and is never stored
	assign reset_chain       = cr_en && HWDATA[0];
	assign cfg.crc_poly_size = crc_poly_size_e'(cr_q[1:0]);
	assign cfg.rev_in_type   = crc_rev_in_e'(cr_q[3:2]);
	assign cfg.rev_out_type  = cr_q[4];

	// Read data by pipelined offset
	always_comb
	begin
		case (haddr_pp)
			CRC_DR:   HRDATA = cfg.crc_out;
			CRC_IDR:  HRDATA = {24'h0, cfg.crc_idr_out};
			CRC_CR:   HRDATA = {24'h0, cr_q, 3'h0};
			CRC_INIT: HRDATA = cfg.crc_init_out;
			CRC_POL:  HRDATA = cfg.crc_poly_out;
			default:  HRDATA = 32'h0;
		endcase
	end

	// A queued word holds off DR reads until the engine has folded it
	a_word_holds_read: assert property (@(posedge HCLK) disable iff (!HRESETn)
		buf_wr.buffer_write_en |=> read_wait);

	// A reset write stays pending until the FSM reloads the CRC
	a_reset_tracked: assert property (@(posedge HCLK) disable iff (!HRESETn)
		reset_chain |=> reset_pending);

endmodule

// ==== crc_input_buffer.sv ====
`timescale 1ns/100ps

module crc_input_buffer import crc_pkg::*; #(
	parameter int BUF_DEPTH = 2
) (
	input  logic      HCLK,
	input  logic      HRESETn,
	crc_buf_if.buffer buf_wr,
	input  logic      buffer_pop,
	output logic      buffer_empty,
	output crc_word_u head_word,
	output crc_size_e head_size,
	input  logic      flush
);

	localparam int PTR_W = $clog2(BUF_DEPTH);
	localparam int CNT_W = $clog2(BUF_DEPTH + 1);

	crc_word_u  word_mem [BUF_DEPTH];
	crc_size_e  size_mem [BUF_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count_q;
	logic [PTR_W-1:0] wr_slot;

	// A write arriving with a flush lands in slot zero
	assign wr_slot = flush ? '0 : wr_ptr;

	always_ff @(posedge HCLK)
	begin
		if (buf_wr.buffer_write_en)
		begin
			word_mem[wr_slot] <= buf_wr.bus_wr;
			size_mem[wr_slot] <= buf_wr.bus_size;
		end
	end

	// Pointers wrap at the depth, which need not be a power of two
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count_q <= '0;
		end
		else if (flush)
		begin
			wr_ptr  <= PTR_W'(buf_wr.buffer_write_en);
			rd_ptr  <= '0;
			count_q <= CNT_W'(buf_wr.buffer_write_en);
		end
		else
		begin
			if (buf_wr.buffer_write_en)
				wr_ptr <= (wr_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (buffer_pop)
				rd_ptr <= (rd_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count_q <= count_q + CNT_W'(buf_wr.buffer_write_en) - CNT_W'(buffer_pop);
		end
	end

	assign buffer_empty       = (count_q == '0);
	assign buf_wr.buffer_full = (count_q == CNT_W'(BUF_DEPTH));
	assign head_word          = word_mem[rd_ptr];
	assign head_size          = size_mem[rd_ptr];

	// Bus slave and FSM both respect the fill level
	a_no_overrun: assert property (@(posedge HCLK) disable iff (!HRESETn)
		!(buf_wr.buffer_write_en && buf_wr.buffer_full) && !(buffer_pop && buffer_empty));

endmodule

// ==== crc_byte_counter.sv ====
`timescale 1ns/100ps

module crc_byte_counter import crc_pkg::*; (
	input  logic       HCLK,
	input  logic       HRESETn,
	input  logic       count_load,
	input  crc_size_e  load_size,
	input  logic       count_dec,
	output logic [1:0] byte_index,
	output logic       count_zero
);

	logic [1:0] count_q;

	// Bytes left minus one, also the lane to fold next
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			count_q <= 2'd0;
		else if (count_load)
		begin
			case (load_size)
				SIZE_BYTE: count_q <= 2'd0;
				SIZE_HALF: count_q <= 2'd1;
				default:   count_q <= 2'd3;
			endcase
		end
		else if (count_dec)
			count_q <= count_q - 2'd1;
	end

	// MSB lane first, so the lane is the remaining count
	assign byte_index = count_q;
	assign count_zero = (count_q == 2'd0);

	// FSM stops decrementing on the last byte
	a_no_underflow: assert property (@(posedge HCLK) disable iff (!HRESETn)
		count_dec |-> !count_zero);

endmodule

// ==== crc_control_fsm.sv ====
`timescale 1ns/100ps

module crc_control_fsm import crc_pkg::*; (
	input  logic      HCLK,
	input  logic      HRESETn,
	input  logic      reset_chain,
	input  logic      buffer_empty,
	input  crc_size_e head_size,
	output logic      buffer_pop,
	output logic      count_load,
	output logic      count_dec,
	output logic      fold_en,
	output logic      crc_reload,
	input  logic      count_zero,
	output logic      read_wait,
	output logic      reset_pending
);

	typedef enum logic [1:0] {IDLE, FOLD, RELOAD} state_e;

	state_e state_q;
	state_e state_nx;
	logic   pend_q;
	logic   reload_req;

	// Reset write seen now or earlier
	assign reload_req = pend_q || reset_chain;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			state_q <= IDLE;
			pend_q  <= 1'b0;
		end
		else
		begin
			state_q <= state_nx;
			pend_q  <= reset_chain || (pend_q && !crc_reload);
		end
	end

	always_comb
	begin
		state_nx   = state_q;
		buffer_pop = 1'b0;
		count_load = 1'b0;
		count_dec  = 1'b0;
		fold_en    = 1'b0;
		crc_reload = 1'b0;
		case (state_q)
			// Reload has priority over new data
			IDLE:
			begin
				if (reload_req)
					state_nx = RELOAD;
				else if (!buffer_empty)
				begin
					count_load = 1'b1;
					state_nx   = FOLD;
				end
			end
			// One byte per cycle, head word leaves with its last byte
			FOLD:
			begin
				fold_en = 1'b1;
				if (count_zero)
				begin
					buffer_pop = 1'b1;
					state_nx   = reload_req ? RELOAD : IDLE;
				end
				else
					count_dec = 1'b1;
			end
			default:
			begin
				crc_reload = 1'b1;
				state_nx   = IDLE;
			end
		endcase
	end

	// CRC is final only with nothing queued and the engine idle
	assign read_wait     = !buffer_empty || (state_q != IDLE);
	assign reset_pending = pend_q;

	// Host never queues a word with the reserved size code
	a_size_valid: assert property (@(posedge HCLK) disable iff (!HRESETn)
		count_load |-> (head_size != crc_size_e'(2'b11)));

endmodule

// ==== crc_datapath.sv ====
`timescale 1ns/100ps

module crc_datapath import crc_pkg::*; (
	input  logic       HCLK,
	input  logic       HRESETn,
	crc_cfg_if.core    cfg,
	input  crc_word_u  head_word,
	input  logic [1:0] byte_index,
	input  logic       fold_en,
	input  logic       crc_reload
);

	localparam logic [31:0] INIT_RESET = 32'hFFFF_FFFF;
	localparam logic [31:0] POLY_RESET = 32'h04C1_1DB7;

	logic [31:0] init_q;
	logic [31:0] poly_q;
	logic [7:0]  idr_q;
	logic [31:0] crc_q;
	crc_word_u   rev_word;
	logic [7:0]  fold_data;
	logic [4:0]  top_bit;
	logic [31:0] width_mask;
	logic [31:0] crc_masked;
	logic [31:0] crc_flipped;

	// Eight MSB-first polynomial steps over one byte
	function automatic logic [31:0] fold_byte(input logic [31:0] crc, input logic [7:0] data,
		input logic [31:0] poly, input logic [31:0] mask, input logic [4:0] top);
		logic        fb;
		logic [31:0] c;
		c = crc;
		for (int b = 7; b >= 0; b--)
		begin
			fb = c[top] ^ data[b];
			c  = (c << 1) & mask;
			if (fb)
				c = c ^ (poly & mask);
		end
		return c;
	endfunction

	//////////////////////////////////////////////////
	// Width and input reversal
	//////////////////////////////////////////////////
	always_comb
	begin
		case (cfg.crc_poly_size)
			POLY_32: top_bit = 5'd31;
			POLY_16: top_bit = 5'd15;
			POLY_8:  top_bit = 5'd7;
			default: top_bit = 5'd6;
		endcase
	end

	assign width_mask = 32'hFFFF_FFFF >> (5'd31 - top_bit);

	always_comb
	begin
		rev_word = head_word;
		case (cfg.rev_in_type)
			REV_BYTE:
				for (int i = 0; i < 4; i++)
					rev_word.bytes[i] = {<<{head_word.bytes[i]}};
			REV_HALF:
				for (int i = 0; i < 2; i++)
					rev_word.half[i] = {<<{head_word.half[i]}};
			REV_WORD:
				rev_word.word = {<<{head_word.word}};
			default: ;
		endcase
	end

	// Lane picked by the byte counter
	assign fold_data = rev_word.bytes[byte_index];

	//////////////////////////////////////////////////
	// Registers
	//////////////////////////////////////////////////
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			init_q <= INIT_RESET;
			poly_q <= POLY_RESET;
			idr_q  <= 8'h00;
		end
		else
		begin
			if (cfg.crc_init_en)
				init_q <= cfg.bus_wr;
			if (cfg.crc_poly_en)
				poly_q <= cfg.bus_wr;
			if (cfg.crc_idr_en)
				idr_q <= cfg.bus_wr[7:0];
		end
	end

	// Running CRC, reload wins over a fold
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			crc_q <= INIT_RESET;
		else if (crc_reload)
			crc_q <= init_q;
		else if (fold_en)
			crc_q <= fold_byte(crc_q, fold_data, poly_q, width_mask, top_bit);
	end

	// Output reversal spans only the configured width
	assign crc_masked  = crc_q & width_mask;
	assign crc_flipped = {<<{crc_masked}};

	assign cfg.crc_out      = cfg.rev_out_type ? (crc_flipped >> (5'd31 - top_bit)) : crc_masked;
	assign cfg.crc_init_out = init_q;
	assign cfg.crc_poly_out = poly_q;
	assign cfg.crc_idr_out  = idr_q;

endmodule

// ==== crc_ahb_top.sv ====
`timescale 1ns/100ps

module crc_ahb_top import crc_pkg::*; #(
	parameter int BUF_DEPTH = 2
) (
	input  logic        HCLK,
	input  logic        HRESETn,
	input  logic [31:0] HADDR,
	input  logic [31:0] HWDATA,
	input  logic [2:0]  HSIZE,
	input  logic [1:0]  HTRANS,
	input  logic        HWRITE,
	input  logic        HSElx,
	input  logic        HREADY,
	output logic [31:0] HRDATA,
	output logic        HREADYOUT,
	output logic        HRESP
);

	crc_word_u  head_word;
	crc_size_e  head_size;
	logic       reset_chain;
	logic       read_wait;
	logic       reset_pending;
	logic       buffer_empty;
	logic       buffer_pop;
	logic       count_load;
	logic       count_dec;
	logic       count_zero;
	logic [1:0] byte_sel;
	logic       fold_en;
	logic       crc_reload;

	crc_cfg_if cfg_if ();
	crc_buf_if buf_if ();

	//////////////////////////////////////////////////
	// Bus slave
	//////////////////////////////////////////////////
	host_interface host_interface_i (
		.HCLK          (HCLK),
		.HRESETn       (HRESETn),
		.HADDR         (HADDR),
		.HWDATA        (HWDATA),
		.HSIZE         (HSIZE),
		.HTRANS        (HTRANS),
		.HWRITE        (HWRITE),
		.HSElx         (HSElx),
		.HREADY        (HREADY),
		.HRDATA        (HRDATA),
		.HREADYOUT     (HREADYOUT),
		.HRESP         (HRESP),
		.cfg           (cfg_if.host),
		.buf_wr        (buf_if.host),
		.reset_chain   (reset_chain),
		.read_wait     (read_wait),
		.reset_pending (reset_pending)
	);

	//////////////////////////////////////////////////
	// CRC engine
	//////////////////////////////////////////////////

	// A reload drops any queued words
	crc_input_buffer #(.BUF_DEPTH(BUF_DEPTH)) crc_input_buffer_i (
		.HCLK         (HCLK),
		.HRESETn      (HRESETn),
		.buf_wr       (buf_if.buffer),
		.buffer_pop   (buffer_pop),
		.buffer_empty (buffer_empty),
		.head_word    (head_word),
		.head_size    (head_size),
		.flush        (crc_reload)
	);

	crc_byte_counter crc_byte_counter_i (
		.HCLK       (HCLK),
		.HRESETn    (HRESETn),
		.count_load (count_load),
		.load_size  (head_size),
		.count_dec  (count_dec),
		.byte_index (byte_sel),
		.count_zero (count_zero)
	);

	crc_control_fsm crc_control_fsm_i (
		.HCLK          (HCLK),
		.HRESETn       (HRESETn),
		.reset_chain   (reset_chain),
		.buffer_empty  (buffer_empty),
		.head_size     (head_size),
		.buffer_pop    (buffer_pop),
		.count_load    (count_load),
		.count_dec     (count_dec),
		.fold_en       (fold_en),
		.crc_reload    (crc_reload),
		.count_zero    (count_zero),
		.read_wait     (read_wait),
		.reset_pending (reset_pending)
	);

	crc_datapath crc_datapath_i (
		.HCLK       (HCLK),
		.HRESETn    (HRESETn),
		.cfg        (cfg_if.core),
		.head_word  (head_word),
		.byte_index (byte_sel),
		.fold_en    (fold_en),
		.crc_reload (crc_reload)
	);

endmodule

// ==== crc_ahb_tb.sv ====
`timescale 1ns/100ps

module crc_ahb_tb;

	localparam int CLK_PERIOD    = 40;
	localparam int MAX_OPS       = 128;
	localparam int CYCLES_PER_OP = 40;

	logic        HCLK;
	logic        HRESETn;
	logic [31:0] HADDR;
	logic [31:0] HWDATA;
	logic [2:0]  HSIZE;
	logic [1:0]  HTRANS;
	logic        HWRITE;
	logic        HSElx;
	logic        HREADY;
	logic [31:0] HRDATA;
	logic        HREADYOUT;
	logic        HRESP;

	// Stimulus table, one entry per bus operation
	string       op_name [MAX_OPS];
	string       op_kind [MAX_OPS];
	logic [2:0]  op_offset [MAX_OPS];
	logic [2:0]  op_size [MAX_OPS];
	logic [31:0] op_data [MAX_OPS];
	int          op_count;
	int          check_count;
	int          error_count;
	logic [31:0] rng_state;
	bit          ops_loaded;

	crc_ahb_top #(.BUF_DEPTH(2)) crc_ahb_top_i (
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.HADDR     (HADDR),
		.HWDATA    (HWDATA),
		.HSIZE     (HSIZE),
		.HTRANS    (HTRANS),
		.HWRITE    (HWRITE),
		.HSElx     (HSElx),
		.HREADY    (HREADY),
		.HRDATA    (HRDATA),
		.HREADYOUT (HREADYOUT),
		.HRESP     (HRESP)
	);

	initial
	begin
		HCLK = 1'b0;
		forever #(CLK_PERIOD / 2) HCLK = ~HCLK;
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	// 32-bit xorshift step for idle gaps
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Reads name, op, offset, size and data per line, skips # lines
	task automatic load_stimulus();
		int          fd;
		int          fields;
		int          ch;
		bit          done;
		string       name;
		string       kind;
		logic [31:0] offset;
		logic [31:0] size;
		logic [31:0] data;
		done = 1'b0;
		fd = $fopen("crc_stimulus.txt", "r");
		if (fd == 0)
		begin
			$display("Cannot open the stimulus file crc_stimulus.txt");
			error_count++;
			done = 1'b1;
		end
		while (!done)
		begin
			fields = $fscanf(fd, "%s", name);
			if (fields != 1 || op_count >= MAX_OPS)
				done = 1'b1;
			else if (name.getc(0) == "#")
			begin
				// Drop the rest of a comment line
				ch = $fgetc(fd);
				while (ch != "\n" && ch != -1)
					ch = $fgetc(fd);
			end
			else
			begin
				fields = $fscanf(fd, " %s %h %h %h", kind, offset, size, data);
				if (fields != 4 || !(kind == "W" || kind == "S" || kind == "R"))
				begin
					$display("Malformed stimulus line for test %s", name);
					error_count++;
					done = 1'b1;
				end
				else
				begin
					op_name[op_count]   = name;
					op_kind[op_count]   = kind;
					op_offset[op_count] = offset[2:0];
					op_size[op_count]   = size[2:0];
					op_data[op_count]   = data;
					op_count++;
				end
			end
		end
		if (fd != 0)
			$fclose(fd);
		if (op_count == 0)
		begin
			$display("No bus operations found in the stimulus file");
			error_count++;
		end
	endtask

	// Ends the current phase once the slave is ready, mid-cycle sample
	task automatic finish_phase(output logic [31:0] rdata, output logic resp);
		do
			@(negedge HCLK);
		while (HREADYOUT !== 1'b1);
		rdata = HRDATA;
		resp  = HRESP;
		@(posedge HCLK);
	endtask

	// Single NONSEQ transfer, address phase then data phase
	task automatic bus_transfer(input bit write, input logic [2:0] offset,
		input logic [2:0] size, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic resp);
		logic [31:0] unused_data;
		logic        unused_resp;
		HSElx  <= 1'b1;
		HTRANS <= 2'b10;
		HADDR  <= {27'h0, offset, 2'b00};
		HWRITE <= write;
		HSIZE  <= size;
		finish_phase(unused_data, unused_resp);
		// Bus goes idle while the data phase runs
		HSElx  <= 1'b0;
		HTRANS <= 2'b00;
		if (write)
			HWDATA <= wdata;
		finish_phase(rdata, resp);
	endtask

	// One stimulus entry with its random idle gap and checks
	task automatic run_op(input int idx);
		int          gap;
		bit          is_write;
		logic [31:0] rdata;
		logic        resp;
		gap = 0;
		if (op_kind[idx] != "S")
		begin
			rng_state = xorshift32(rng_state);
			gap = rng_state[1:0];
		end
		repeat (gap) @(posedge HCLK);
		is_write = (op_kind[idx] != "R");
		bus_transfer(is_write, op_offset[idx], op_size[idx], op_data[idx], rdata, resp);
		check_count++;
		if (resp !== 1'b0)
		begin
			error_count++;
			$display("CHECK FAILED %s HRESP: expected 0, actual %b", op_name[idx], resp);
		end
		if (!is_write)
		begin
			check_count++;
			if (rdata !== op_data[idx])
			begin
				error_count++;
				$display("CHECK FAILED %s: expected %h, actual %h",
					op_name[idx], op_data[idx], rdata);
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////
	initial
	begin
		HRESETn <= 1'b0;
		HADDR   <= 32'h0;
		HWDATA  <= 32'h0;
		HSIZE   <= 3'b010;
		HTRANS  <= 2'b00;
		HWRITE  <= 1'b0;
		HSElx   <= 1'b0;
		// Only slave on the bus
		HREADY  <= 1'b1;
		op_count    = 0;
		check_count = 0;
		error_count = 0;
		rng_state   = 32'd25078;
		load_stimulus();
		ops_loaded = 1'b1;
		repeat (8) @(posedge HCLK);
		HRESETn <= 1'b1;
		for (int i = 0; i < op_count; i++)
			run_op(i);
		repeat (2) @(posedge HCLK);
		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	// Watchdog, budget scales with the stimulus length
	initial
	begin
		wait (ops_loaded);
		#((16 + op_count * CYCLES_PER_OP) * CLK_PERIOD);
		$display("Timeout: the bus operations did not finish in %0d clock cycles",
			16 + op_count * CYCLES_PER_OP);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== crc_ahb_top.f ====
crc_pkg.sv
crc_if.sv
host_interface.sv
crc_input_buffer.sv
crc_byte_counter.sv
crc_control_fsm.sv
crc_datapath.sv
crc_ahb_top.sv
crc_ahb_tb.sv

// ==== crc_stimulus.txt ====
# name  op  offset  size  data
# op W writes, S writes with no idle cycle before it, R reads and compares with data
rst_cr    R 2 2 00000000
rst_init  R 4 2 ffffffff
rst_pol   R 5 2 04c11db7
rst_dr    R 0 2 ffffffff
# Back-to-back words overrun the two-entry FIFO
stream    S 0 2 ffffffff
stream    S 0 2 00000000
stream    S 0 2 00000000
stream    S 0 2 00000001
stream    R 0 2 04c11db7
# Feeding the register contents back in leaves zero
residue   S 0 2 04c11db7
residue   R 0 2 00000000
# ASCII 123456789 as halfword, byte, word, halfword
mixed     W 2 2 00000001
mixed     W 0 1 00003132
mixed     W 0 0 00000033
mixed     W 0 2 34353637
mixed     W 0 1 00003839
mixed     R 0 2 0376e6e7
# Reset bit loads the INIT value held before the new write
reload    W 4 2 12345678
reload    W 2 2 00000001
reload    W 4 2 cafef00d
reload    R 0 2 12345678
reload    R 4 2 cafef00d
idr       W 1 2 123456a5
idr       R 1 2 000000a5
# CCITT 16-bit
crc16     W 5 2 00001021
crc16     W 4 2 0000ffff
crc16     W 2 2 00000009
crc16     R 2 2 00000008
crc16     W 0 1 00003132
crc16     W 0 1 00003334
crc16     W 0 1 00003536
crc16     W 0 1 00003738
crc16     W 0 0 00000039
crc16     R 0 2 000029b1
crc8      W 5 2 00000007
crc8      W 4 2 00000000
crc8      W 2 2 00000011
crc8      W 0 2 31323334
crc8      W 0 2 35363738
crc8      W 0 0 00000039
crc8      R 0 2 000000f4
crc7      W 5 2 00000009
crc7      W 2 2 00000019
crc7      W 0 2 31323334
crc7      W 0 2 35363738
crc7      W 0 0 00000039
crc7      R 0 2 00000075
# Reflected input with reflected output, back to 32-bit defaults
rev_byte  W 5 2 04c11db7
rev_byte  W 4 2 ffffffff
rev_byte  W 2 2 000000a1
rev_byte  W 0 2 31323334
rev_byte  W 0 2 35363738
rev_byte  W 0 0 00000039
rev_byte  R 0 2 340bc6d9
rev_half  W 2 2 000000c1
rev_half  W 0 1 00003231
rev_half  W 0 1 00003433
rev_half  W 0 1 00003635
rev_half  W 0 1 00003837
rev_half  W 0 0 00003900
rev_half  R 0 2 340bc6d9
rev_word  W 2 2 000000e1
rev_word  W 0 2 34333231
rev_word  W 0 2 38373635
rev_word  W 0 0 39000000
rev_word  R 0 2 340bc6d9
rev_out   W 2 2 00000081
rev_out   W 0 2 31323334
rev_out   W 0 2 35363738
rev_out   W 0 0 00000039
rev_out   R 0 2 e7676ec0
